/* dataCache.f */
hdl/cachePkg.sv
hdl/cacheArrayIf.sv
hdl/tagStore.sv
hdl/dataStore.sv
hdl/cacheCtrl.sv
hdl/dataCache.sv
sim/memModel.sv
sim/dataCacheTb.sv

/* Makefile */
SRCS := $(wildcard hdl/*.sv sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/VdataCacheTb: dataCache.f $(SRCS)
	verilator --binary --timing --assert -f dataCache.f --top-module dataCacheTb -Mdir obj_dir

run: obj_dir/VdataCacheTb
	./obj_dir/VdataCacheTb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/dataCacheTb.sv */
`timescale 1ns/1ns

module dataCacheTb;
    import cachePkg::*;

    localparam int TIMEOUT = 60;
    localparam logic [63:0] BASE = 64'h0000_0000_0000_1000;

    logic clk = 1'b0;
    logic rst;
    logic reqValid;
    logic reqWrite;
    logic [63:0] reqAddr;
    logic [63:0] reqData;
    logic [7:0] reqMask;
    logic reqReady;
    logic respValid;
    logic [63:0] respData;
    logic memReqValid;
    logic memWrite;
    logic [63:0] memAddr;
    logic [63:0] memWData;
    logic [7:0] memMask;
    logic memReqReady;
    logic memRespValid;
    logic [63:0] memRData;

    // Reference model: memory shadow and a copy of the tag state.
    logic [63:0] shadow [logic [60:0]];
    logic [TAG_W-1:0] refTag [2][NUM_SETS];
    logic refValid [2][NUM_SETS];
    logic refVictim [NUM_SETS];

    // Expected behavior of the request in flight.
    logic expHitResp;
    logic expWrite;
    logic [63:0] expAddr;
    logic [63:0] expWData;
    logic [7:0] expMask;
    logic [63:0] expData;
    int expMemCount;
    int memCount = 0;

    always #20 clk = ~clk;

    dataCache dut0 (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .reqWrite(reqWrite),
        .reqAddr(reqAddr),
        .reqData(reqData),
        .reqMask(reqMask),
        .reqReady(reqReady),
        .respValid(respValid),
        .respData(respData),
        .memReqValid(memReqValid),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memWData(memWData),
        .memMask(memMask),
        .memReqReady(memReqReady),
        .memRespValid(memRespValid),
        .memRData(memRData)
    );

    memModel mem0 (
        .clk(clk),
        .rst(rst),
        .memReqValid(memReqValid),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memWData(memWData),
        .memMask(memMask),
        .memReqReady(memReqReady),
        .memRespValid(memRespValid),
        .memRData(memRData)
    );

    // Memory requests made for the current core request.
    always @(posedge clk) begin
        if (reqValid && reqReady) begin
            memCount <= 0;
        end else if (memReqValid && memReqReady) begin
            memCount <= memCount + 1;
        end
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportMismatch(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        failRun($sformatf("[FAIL] %s expected 0x%h, actual 0x%h", name, expected, actual));
    endtask

    assert property (@(posedge clk) $past(rst) |-> !respValid && !memReqValid && reqReady)
        else failRun("reset left respValid, memReqValid or reqReady in the wrong state");

    assert property (@(posedge clk) disable iff (rst) respValid |-> respData == expData)
        else reportMismatch("respData", $sampled(expData), $sampled(respData));

    // A load hit answers in the cycle right after acceptance.
    assert property (@(posedge clk) disable iff (rst)
        reqValid && reqReady |=> respValid == expHitResp)
        else reportMismatch("respValid", 64'($sampled(expHitResp)), 64'($sampled(respValid)));

    assert property (@(posedge clk) disable iff (rst)
        reqValid && reqReady && expHitResp |=> !memReqValid)
        else failRun("a load hit raised memReqValid");

    assert property (@(posedge clk) disable iff (rst) respValid |-> memCount == expMemCount)
        else reportMismatch("memCount", 64'($sampled(expMemCount)), 64'($sampled(memCount)));

    assert property (@(posedge clk) disable iff (rst)
        memReqValid && memReqReady |-> memWrite == expWrite)
        else reportMismatch("memWrite", 64'($sampled(expWrite)), 64'($sampled(memWrite)));

    assert property (@(posedge clk) disable iff (rst)
        memReqValid && memReqReady |-> memAddr == expAddr)
        else reportMismatch("memAddr", $sampled(expAddr), $sampled(memAddr));

    assert property (@(posedge clk) disable iff (rst)
        memReqValid && memReqReady && memWrite |-> memWData == expWData)
        else reportMismatch("memWData", $sampled(expWData), $sampled(memWData));

    assert property (@(posedge clk) disable iff (rst)
        memReqValid && memReqReady && memWrite |-> memMask == expMask)
        else reportMismatch("memMask", 64'($sampled(expMask)), 64'($sampled(memMask)));

    function automatic logic [63:0] untouchedWord(input logic [60:0] wordAddr);
        return {wordAddr, 3'b101} ^ 64'hc3a5_5a3c_0f1e_2d4b;
    endfunction

    task automatic stepCycle();
        @(posedge clk);
        #2;
    endtask

    // Predicts the outcome and updates the reference model.
    task automatic predict(input logic write, input logic [63:0] addr,
            input logic [63:0] data, input logic [7:0] mask);
        logic [60:0] key;
        logic [INDEX_W-1:0] setIdx;
        logic [TAG_W-1:0] tag;
        logic hit;
        logic way;
        logic [63:0] word;
        key = addr[63:3];
        setIdx = addr[4:3];
        tag = addr[63:5];
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (refValid[w][setIdx] && refTag[w][setIdx] == tag) begin
                hit = 1'b1;
            end
        end
        word = shadow.exists(key) ? shadow[key] : untouchedWord(key);
        expWrite = write;
        expAddr = addr;
        expWData = data;
        expMask = mask;
        expHitResp = !write && hit;
        expMemCount = expHitResp ? 0 : 1;
        if (write) begin
            for (int b = 0; b < 8; b++) begin
                if (mask[b]) begin
                    word[8*b +: 8] = data[8*b +: 8];
                end
            end
            shadow[key] = word;
            expData = '0;
        end else begin
            expData = word;
            if (!hit) begin
                way = refVictim[setIdx];
                refTag[way][setIdx] = tag;
                refValid[way][setIdx] = 1'b1;
                refVictim[setIdx] = !way;
            end
        end
    endtask

    task automatic waitReady();
        int n;
        n = 0;
        while (!reqReady && n < TIMEOUT) begin
            stepCycle();
            n++;
        end
        if (!reqReady) begin
            failRun("timed out waiting for reqReady");
        end
    endtask

    task automatic waitResponse();
        int n;
        n = 0;
        while (!respValid && n < TIMEOUT) begin
            stepCycle();
            n++;
        end
        if (!respValid) begin
            failRun("timed out waiting for respValid");
        end
    endtask

    task automatic sendRequest(input logic write, input logic [63:0] addr,
            input logic [63:0] data, input logic [7:0] mask);
        waitReady();
        predict(write, addr, data, mask);
        reqValid = 1'b1;
        reqWrite = write;
        reqAddr = addr;
        reqData = data;
        reqMask = mask;
        stepCycle();
        reqValid = 1'b0;
        waitResponse();
        stepCycle();
    endtask

    initial begin
        logic [63:0] addr;
        logic write;
        void'($urandom(45057));
        rst = 1'b1;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        reqData = '0;
        reqMask = '0;
        expHitResp = 1'b0;
        expWrite = 1'b0;
        expAddr = '0;
        expWData = '0;
        expMask = '0;
        expData = '0;
        expMemCount = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            refValid[0][s] = 1'b0;
            refValid[1][s] = 1'b0;
            refVictim[s] = 1'b0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // Miss, then an immediate hit on the same word.
        sendRequest(1'b0, BASE, '0, '0);
        sendRequest(1'b0, BASE, '0, '0);
        // Masked store hit and the merged word read back.
        sendRequest(1'b1, BASE, 64'h1122_3344_5566_7788, 8'h0f);
        sendRequest(1'b0, BASE, '0, '0);
        // Store miss leaves the set untouched.
        sendRequest(1'b1, BASE + 64'h108, 64'hfeed_beef_cafe_f00d, 8'ha5);
        sendRequest(1'b0, BASE + 64'h108, '0, '0);
        // Three tags in set 2, the third fill evicts the first.
        sendRequest(1'b0, BASE + 64'h010, '0, '0);
        sendRequest(1'b0, BASE + 64'h210, '0, '0);
        sendRequest(1'b0, BASE + 64'h410, '0, '0);
        sendRequest(1'b0, BASE + 64'h210, '0, '0);
        sendRequest(1'b0, BASE + 64'h010, '0, '0);

        for (int i = 0; i < 200; i++) begin
            addr = BASE + 64'($urandom_range(15, 0)) * 64'd8;
            write = 1'($urandom_range(1, 0));
            sendRequest(write, addr, {$urandom(), $urandom()}, 8'($urandom()));
        end

        stepCycle();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* sim/memModel.sv */
`timescale 1ns/1ns

module memModel (
    input logic clk,
    input logic rst,
    input logic memReqValid,
    input logic memWrite,
    input logic [63:0] memAddr,
    input logic [63:0] memWData,
    input logic [7:0] memMask,
    output logic memReqReady,
    output logic memRespValid,
    output logic [63:0] memRData
);

    // Sparse word store, keyed by the word address.
    logic [63:0] words [logic [60:0]];

    // Contents of a word that was never written.
    function automatic logic [63:0] untouchedWord(input logic [60:0] wordAddr);
        return {wordAddr, 3'b101} ^ 64'hc3a5_5a3c_0f1e_2d4b;
    endfunction

    initial begin
        int unsigned delay;
        logic [60:0] key;
        logic write;
        logic [63:0] wdata;
        logic [7:0] mask;
        logic [63:0] word;
        memReqReady = 1'b0;
        memRespValid = 1'b0;
        memRData = '0;
        forever begin
            @(posedge clk);
            #2;
            memReqReady = 1'b0;
            memRespValid = 1'b0;
            if (!rst && memReqValid) begin
                delay = $urandom_range(3, 0);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                key = memAddr[63:3];
                write = memWrite;
                wdata = memWData;
                mask = memMask;
                memReqReady = 1'b1;
                // Request is taken on this edge.
                @(posedge clk);
                #2;
                memReqReady = 1'b0;
                word = words.exists(key) ? words[key] : untouchedWord(key);
                if (write) begin
                    for (int b = 0; b < 8; b++) begin
                        if (mask[b]) begin
                            word[8*b +: 8] = wdata[8*b +: 8];
                        end
                    end
                    words[key] = word;
                end
                memRData = word;
                memRespValid = 1'b1;
            end
        end
    end

endmodule

/* hdl/dataCache.sv */
`timescale 1ns/1ns

module dataCache (
    input logic clk,
    input logic rst,
    input logic reqValid,
    input logic reqWrite,
    input logic [63:0] reqAddr,
    input logic [63:0] reqData,
    input logic [7:0] reqMask,
    output logic reqReady,
    output logic respValid,
    output logic [63:0] respData,
    output logic memReqValid,
    output logic memWrite,
    output logic [63:0] memAddr,
    output logic [63:0] memWData,
    output logic [7:0] memMask,
    input logic memReqReady,
    input logic memRespValid,
    input logic [63:0] memRData
);

    cacheArrayIf arrIf ();

    cacheCtrl ctrl0 (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .reqWrite(reqWrite),
        .reqAddr(reqAddr),
        .reqData(reqData),
        .reqMask(reqMask),
        .reqReady(reqReady),
        .respValid(respValid),
        .respData(respData),
        .memReqValid(memReqValid),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memWData(memWData),
        .memMask(memMask),
        .memReqReady(memReqReady),
        .memRespValid(memRespValid),
        .memRData(memRData),
        .arr(arrIf.ctrl)
    );

    tagStore tagStore0 (
        .clk(clk),
        .rst(rst),
        .arr(arrIf.tags)
    );

    dataStore dataStore0 (
        .clk(clk),
        .arr(arrIf.data)
    );

endmodule

/* hdl/cacheCtrl.sv */
`timescale 1ns/1ns

module cacheCtrl (
    input logic clk,
    input logic rst,
    input logic reqValid,
    input logic reqWrite,
    input logic [63:0] reqAddr,
    input logic [63:0] reqData,
    input logic [7:0] reqMask,
    output logic reqReady,
    output logic respValid,
    output logic [63:0] respData,
    output logic memReqValid,
    output logic memWrite,
    output logic [63:0] memAddr,
    output logic [63:0] memWData,
    output logic [7:0] memMask,
    input logic memReqReady,
    input logic memRespValid,
    input logic [63:0] memRData,
    cacheArrayIf.ctrl arr
);
    import cachePkg::*;

    ctrlState state;
    ctrlState nextState;

    // Accepted request.
    logic writeReg;
    cacheAddr addrReg;
    logic [63:0] dataReg;
    logic [7:0] maskReg;

    logic [63:0] respWord;
    logic loadHit;

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            writeReg <= reqWrite;
            addrReg.raw <= reqAddr;
            dataReg <= reqData;
            maskReg <= reqMask;
        end
    end

    // Word returned after a memory round trip, zero for stores.
    always_ff @(posedge clk) begin
        if (state == MEMWAIT && memRespValid) begin
            respWord <= writeReg ? 64'h0 : memRData;
        end
    end

    always_comb begin
        nextState = state;
        unique case (state)
            IDLE: begin
                if (reqValid) begin
                    nextState = LOOKUP;
                end
            end
            LOOKUP: nextState = loadHit ? IDLE : MEMREQ;
            MEMREQ: begin
                if (memReqReady) begin
                    nextState = MEMWAIT;
                end
            end
            MEMWAIT: begin
                if (memRespValid) begin
                    nextState = RESPOND;
                end
            end
            RESPOND: nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    assign loadHit = !writeReg && arr.hit;

    // Array side.
    assign arr.index = addrReg.fields.index;
    assign arr.tag = addrReg.fields.tag;
    assign arr.fill = (state == MEMWAIT) && memRespValid && !writeReg;
    assign arr.fillData = memRData;
    assign arr.merge = (state == LOOKUP) && writeReg && arr.hit;
    assign arr.mergeData = dataReg;
    assign arr.mergeMask = maskReg;

    // Core side. Hits answer straight from the arrays in the lookup cycle.
    assign reqReady = (state == IDLE);
    assign respValid = ((state == LOOKUP) && loadHit) || (state == RESPOND);
    assign respData = (state == LOOKUP) ? arr.readData : respWord;

    // Memory side.
    assign memReqValid = (state == MEMREQ);
    assign memWrite = writeReg;
    assign memAddr = addrReg.raw;
    assign memWData = dataReg;
    assign memMask = writeReg ? maskReg : 8'hff;

    // Memory request holds while the port stalls.
    assert property (@(posedge clk) disable iff (rst)
        memReqValid && !memReqReady |=> memReqValid && $stable(memAddr))
        else $error("cacheCtrl: memory request changed under back-pressure");

endmodule

/* hdl/dataStore.sv */
`timescale 1ns/1ns

module dataStore (
    input logic clk,
    cacheArrayIf.data arr
);
    import cachePkg::*;

    logic [63:0] words [2][NUM_SETS];
    logic [63:0] merged;

    // Output follows the hit way, don't care on a miss.
    assign arr.readData = words[arr.hitWay][arr.index];

    // Masked bytes replace the cached ones.
    always_comb begin
        merged = arr.readData;
        for (int b = 0; b < 8; b++) begin
            if (arr.mergeMask[b]) begin
                merged[8*b +: 8] = arr.mergeData[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr.fill) begin
            words[arr.victimWay][arr.index] <= arr.fillData;
        end else if (arr.merge) begin
            words[arr.hitWay][arr.index] <= merged;
        end
    end

    // Refill and store merge come from different controller states.
    assert property (@(posedge clk)
        !(arr.fill && arr.merge))
        else $error("dataStore: fill and merge in the same cycle");

endmodule

/* hdl/tagStore.sv */
`timescale 1ns/1ns

module tagStore (
    input logic clk,
    input logic rst,
    cacheArrayIf.tags arr
);
    import cachePkg::*;

    logic [TAG_W-1:0] tags [2][NUM_SETS];
    logic [1:0][NUM_SETS-1:0] valid;
    logic [NUM_SETS-1:0] victim;
    logic [1:0] wayHit;

    // Both ways of the set are compared in parallel.
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = valid[w][arr.index] && (tags[w][arr.index] == arr.tag);
        end
    end

    assign arr.hit = |wayHit;
    assign arr.hitWay = wayHit[1];
    assign arr.victimWay = victim[arr.index];

    // Victim bit flips on refill only.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            victim <= '0;
        end else if (arr.fill) begin
            valid[arr.victimWay][arr.index] <= 1'b1;
            victim[arr.index] <= ~victim[arr.index];
        end
    end

    always_ff @(posedge clk) begin
        if (arr.fill) begin
            tags[arr.victimWay][arr.index] <= arr.tag;
        end
    end

    // A tag lives in at most one way of a set.
    assert property (@(posedge clk) disable iff (rst)
        !(wayHit[0] && wayHit[1]))
        else $error("tagStore: both ways hit in set %0d", arr.index);

endmodule

/* hdl/cacheArrayIf.sv */
`timescale 1ns/1ns

interface cacheArrayIf;
    import cachePkg::*;

    // Set lookup, driven by the controller.
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0] tag;

    // Refill of the victim way.
    logic fill;
    logic [63:0] fillData;

    // Byte-masked store into the hit way.
    logic merge;
    logic [63:0] mergeData;
    logic [7:0] mergeMask;

    // Lookup results.
    logic hit;
    logic hitWay;
    logic victimWay;
    logic [63:0] readData;

    modport ctrl (
        output index, tag, fill, fillData, merge, mergeData, mergeMask,
        input hit, readData
    );

    modport tags (
        input index, tag, fill,
        output hit, hitWay, victimWay
    );

    modport data (
        input index, fill, fillData, merge, mergeData, mergeMask, hitWay, victimWay,
        output readData
    );

endinterface

/* hdl/cachePkg.sv */
package cachePkg;

    // One cached line holds a single 64-bit word.
    localparam int OFFSET_W = 3;
    localparam int INDEX_W = 2;
    localparam int TAG_W = 64 - INDEX_W - OFFSET_W;
    localparam int NUM_SETS = 1 << INDEX_W;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [INDEX_W-1:0] index;
        logic [OFFSET_W-1:0] offset;
    } addrFields;

    // The same address word, seen whole by memory and split by the arrays.
    typedef union packed {
        logic [63:0] raw;
        addrFields fields;
    } cacheAddr;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEMREQ,
        MEMWAIT,
        RESPOND
    } ctrlState;

endpackage
